/* icache_defines.svh */
// Instruction cache geometry

`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// ==============================
// Address and word widths
// ==============================

// Core and memory byte address
`define ICACHE_ADDR_BITS 32

// One instruction word
`define ICACHE_WORD_BITS 32

// ==============================
// Line geometry
// ==============================

// Words held by one line
`define ICACHE_LINE_WORDS 4

// Byte offset inside a line
`define ICACHE_OFFSET_BITS 4

// Line index, 64 lines
`define ICACHE_INDEX_BITS 6

// Remaining upper address bits
`define ICACHE_TAG_BITS 22

// Number of lines in the arrays
`define ICACHE_LINES 64

`endif

/* icache_pkg.sv */
// Instruction cache types

`default_nettype none

`include "icache_defines.svh"

package icache_pkg;

  // ==============================
  // Vector types
  // ==============================

  // Byte address from the core
  typedef logic [`ICACHE_ADDR_BITS-1:0] addr_t;

  // Instruction word
  typedef logic [`ICACHE_WORD_BITS-1:0] word_t;

  // Whole line, word 0 in the low bits
  typedef logic [`ICACHE_LINE_WORDS*`ICACHE_WORD_BITS-1:0] line_t;

  typedef logic [`ICACHE_TAG_BITS-1:0] tag_t;
  typedef logic [`ICACHE_INDEX_BITS-1:0] index_t;

  // Word within a line, address bits 3:2
  typedef logic [`ICACHE_OFFSET_BITS-3:0] word_sel_t;

  // ==============================
  // Structs
  // ==============================

  // Single word read request to memory
  typedef struct packed {
    logic  valid;
    addr_t addr;
  } mem_req_t;

  // Order to fetch one line, base is the address without offset
  typedef struct packed {
    logic                                         start;
    logic [`ICACHE_ADDR_BITS-`ICACHE_OFFSET_BITS-1:0] base;
  } refill_cmd_t;

  // Assembled line with its done pulse
  typedef struct packed {
    logic  done;
    line_t line;
  } refill_rsp_t;

  // Write into tag, valid and data arrays
  typedef struct packed {
    logic   en;
    index_t index;
    tag_t   tag;
    line_t  line;
  } array_wr_t;

  // ==============================
  // State machines
  // ==============================

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_LOOKUP,
    CTRL_REFILL,
    CTRL_FILL
  } ctrl_state_e;

  typedef enum logic [1:0] {
    REFILL_IDLE,
    REFILL_ISSUE,
    REFILL_WAIT
  } refill_state_e;

endpackage

`default_nettype wire

/* icache_tag_store.sv */
// Tag array and valid bits

`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_tag_store (
  input  logic                  clk,
  input  logic                  rst,
  input  icache_pkg::index_t    index,
  input  logic                  rd_en,
  input  icache_pkg::array_wr_t wr,
  output icache_pkg::tag_t      tag_out,
  output logic                  valid_out
);

  import icache_pkg::*;

  // Behavioral tag memory
  tag_t tag_mem [`ICACHE_LINES];

  // One valid flop per line
  logic [`ICACHE_LINES-1:0] valid_q;

  // ==============================
  // Tag array
  // ==============================

  // Written once per refill, in the fill cycle
  always_ff @(posedge clk)
  begin
    if (wr.en)
    begin
      tag_mem[wr.index] <= wr.tag;
    end
  end

  // Registered read, result seen in the lookup cycle
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      tag_out <= tag_mem[index];
    end
  end

  // ==============================
  // Valid bits
  // ==============================

  // Cleared by reset, set by a line fill
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_q <= '0;
    end
    else if (wr.en)
    begin
      valid_q[wr.index] <= 1'b1;
    end
  end

  // Valid read travels with the tag read
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      valid_out <= 1'b0;
    end
    else if (rd_en)
    begin
      valid_out <= valid_q[index];
    end
  end

endmodule

`default_nettype wire

/* icache_data_store.sv */
// Cache line data array

`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_data_store (
  input  logic                  clk,
  input  icache_pkg::index_t    index,
  input  logic                  rd_en,
  input  icache_pkg::array_wr_t wr,
  output icache_pkg::line_t     line_out
);

  import icache_pkg::*;

  // 64 lines of four words each
  line_t line_mem [`ICACHE_LINES];

  // ==============================
  // Write port
  // ==============================

  // Whole line at once, no byte masks on a read-only cache
  always_ff @(posedge clk)
  begin
    if (wr.en)
    begin
      line_mem[wr.index] <= wr.line;
    end
  end

  // ==============================
  // Read port
  // ==============================

  // Line is ready one cycle after rd_en
  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      line_out <= line_mem[index];
    end
  end

endmodule

`default_nettype wire

/* icache_refill.sv */
// Four-beat line refill engine

`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_refill (
  input  logic                    clk,
  input  logic                    rst,
  input  icache_pkg::refill_cmd_t cmd,
  output icache_pkg::refill_rsp_t rsp,
  output icache_pkg::mem_req_t    mem_req,
  input  icache_pkg::word_t       mem_rdata,
  input  logic                    mem_wait
);

  import icache_pkg::*;

  refill_state_e state_q;
  refill_state_e state_d;

  // Word currently requested, 0 to 3
  word_sel_t beat_q;

  // Line base held for the whole refill
  logic [`ICACHE_ADDR_BITS-`ICACHE_OFFSET_BITS-1:0] base_q;

  // Incoming words shift in from the top
  line_t line_q;
  logic  done_q;

  // Word returned in this cycle
  logic  beat_done;
  logic  last_beat;

  assign beat_done = (state_q == REFILL_WAIT) && !mem_wait;
  assign last_beat = (beat_q == word_sel_t'(`ICACHE_LINE_WORDS - 1));

  // ==============================
  // State machine
  // ==============================

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      REFILL_IDLE:
      begin
        if (cmd.start)
        begin
          state_d = REFILL_ISSUE;
        end
      end
      // One request pulse, then wait for the word
      REFILL_ISSUE:
      begin
        state_d = REFILL_WAIT;
      end
      REFILL_WAIT:
      begin
        if (beat_done)
        begin
          state_d = last_beat ? REFILL_IDLE : REFILL_ISSUE;
        end
      end
      default:
      begin
        state_d = REFILL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q <= REFILL_IDLE;
      beat_q  <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      // Done follows the last word by one cycle
      done_q  <= beat_done && last_beat;
      if (state_q == REFILL_IDLE && cmd.start)
      begin
        beat_q <= '0;
      end
      else if (beat_done)
      begin
        beat_q <= beat_q + 1'b1;
      end
    end
  end

  // ==============================
  // Datapath
  // ==============================

  always_ff @(posedge clk)
  begin
    if (state_q == REFILL_IDLE && cmd.start)
    begin
      base_q <= cmd.base;
    end
    // Word 0 ends up in the low bits after four shifts
    if (beat_done)
    begin
      line_q <= {mem_rdata, line_q[$bits(line_t)-1:`ICACHE_WORD_BITS]};
    end
  end

  // Word address is base plus 4 per beat
  assign mem_req.valid = (state_q == REFILL_ISSUE);
  assign mem_req.addr  = {base_q, beat_q, 2'b00};

  assign rsp.done = done_q;
  assign rsp.line = line_q;

endmodule

`default_nettype wire

/* icache_ctrl.sv */
// Fetch controller, hit check and word select

`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module icache_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    core_req,
  input  icache_pkg::addr_t       core_addr,
  output icache_pkg::word_t       core_out,
  output logic                    core_wait,
  output icache_pkg::index_t      index,
  output logic                    rd_en,
  input  icache_pkg::tag_t        tag_in,
  input  logic                    valid_in,
  input  icache_pkg::line_t       line_in,
  output icache_pkg::array_wr_t   wr,
  output icache_pkg::refill_cmd_t refill_cmd,
  input  icache_pkg::refill_rsp_t refill_rsp
);

  import icache_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;

  // Fetch address captured on acceptance
  addr_t addr_q;

  // Refilled line kept for the fill cycle
  line_t fill_line_q;

  logic      accept;
  logic      hit;
  tag_t      addr_tag;
  index_t    addr_index;
  word_sel_t addr_word;
  line_t     sel_line;
  logic      out_load;

  // Address fields of the captured fetch
  assign addr_tag   = addr_q[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  assign addr_index = addr_q[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
  assign addr_word  = addr_q[`ICACHE_OFFSET_BITS-1:2];

  // New fetch only while idle
  assign accept = (state_q == CTRL_IDLE) && core_req;

  // Tag and valid arrive in the lookup cycle
  assign hit = valid_in && (tag_in == addr_tag);

  // ==============================
  // State machine
  // ==============================

  always_comb
  begin
    state_d = state_q;
    unique case (state_q)
      CTRL_IDLE:
      begin
        if (accept)
        begin
          state_d = CTRL_LOOKUP;
        end
      end
      CTRL_LOOKUP:
      begin
        state_d = hit ? CTRL_IDLE : CTRL_REFILL;
      end
      // Held here for as long as memory stretches
      CTRL_REFILL:
      begin
        if (refill_rsp.done)
        begin
          state_d = CTRL_FILL;
        end
      end
      CTRL_FILL:
      begin
        state_d = CTRL_IDLE;
      end
      default:
      begin
        state_d = CTRL_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state_q <= CTRL_IDLE;
    end
    else
    begin
      state_q <= state_d;
    end
  end

  // ==============================
  // Core side
  // ==============================

  // Rises with core_req, low again when the word is on core_out
  assign core_wait = (state_q == CTRL_IDLE) ? core_req : 1'b1;

  // Hit takes the array line, miss the refilled one
  assign sel_line = (state_q == CTRL_LOOKUP) ? line_in : fill_line_q;
  assign out_load = ((state_q == CTRL_LOOKUP) && hit) || (state_q == CTRL_FILL);

  always_ff @(posedge clk)
  begin
    if (accept)
    begin
      addr_q <= core_addr;
    end
    if ((state_q == CTRL_REFILL) && refill_rsp.done)
    begin
      fill_line_q <= refill_rsp.line;
    end
    // Holds its value while idle
    if (out_load)
    begin
      core_out <= sel_line[addr_word*`ICACHE_WORD_BITS +: `ICACHE_WORD_BITS];
    end
  end

  // ==============================
  // Arrays and refill
  // ==============================

  // Arrays read with the incoming address
  assign rd_en = accept;
  assign index = core_addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];

  // Fill writes at the captured address
  assign wr.en    = (state_q == CTRL_FILL);
  assign wr.index = addr_index;
  assign wr.tag   = addr_tag;
  assign wr.line  = fill_line_q;

  // Start lasts the single miss cycle of lookup
  assign refill_cmd.start = (state_q == CTRL_LOOKUP) && !hit;
  assign refill_cmd.base  = addr_q[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS];

endmodule

`default_nettype wire

/* icache_top.sv */
// Instruction cache top level

`timescale 1ns/1ps
`default_nettype none

module icache_top (
  input  logic              clk,
  input  logic              rst,
  // Core side
  input  logic              core_req,
  input  icache_pkg::addr_t core_addr,
  output icache_pkg::word_t core_out,
  output logic              core_wait,
  // Memory side
  output logic              mem_req,
  output icache_pkg::addr_t mem_addr,
  input  icache_pkg::word_t mem_rdata,
  input  logic              mem_wait
);

  import icache_pkg::*;

  index_t      index;
  logic        rd_en;
  tag_t        tag_rd;
  logic        valid_rd;
  line_t       line_rd;
  array_wr_t   array_wr;
  refill_cmd_t refill_cmd;
  refill_rsp_t refill_rsp;
  mem_req_t    mem_req_s;

  // ==============================
  // Instances
  // ==============================

  icache_ctrl u_ctrl (
    .clk        (clk),
    .rst        (rst),
    .core_req   (core_req),
    .core_addr  (core_addr),
    .core_out   (core_out),
    .core_wait  (core_wait),
    .index      (index),
    .rd_en      (rd_en),
    .tag_in     (tag_rd),
    .valid_in   (valid_rd),
    .line_in    (line_rd),
    .wr         (array_wr),
    .refill_cmd (refill_cmd),
    .refill_rsp (refill_rsp)
  );

  icache_refill u_refill (
    .clk       (clk),
    .rst       (rst),
    .cmd       (refill_cmd),
    .rsp       (refill_rsp),
    .mem_req   (mem_req_s),
    .mem_rdata (mem_rdata),
    .mem_wait  (mem_wait)
  );

  icache_tag_store u_tag_store (
    .clk       (clk),
    .rst       (rst),
    .index     (index),
    .rd_en     (rd_en),
    .wr        (array_wr),
    .tag_out   (tag_rd),
    .valid_out (valid_rd)
  );

  icache_data_store u_data_store (
    .clk      (clk),
    .index    (index),
    .rd_en    (rd_en),
    .wr       (array_wr),
    .line_out (line_rd)
  );

  // Memory request split onto the bus pins
  assign mem_req  = mem_req_s.valid;
  assign mem_addr = mem_req_s.addr;

endmodule

`default_nettype wire

/* tb_mem_model.sv */
// Behavioral instruction memory

`timescale 1ns/1ps
`default_nettype none

module tb_mem_model #(
  parameter icache_pkg::word_t PATTERN = '0,
  parameter logic [31:0]       SEED    = '0
) (
  input  logic              clk,
  input  logic              rst,
  input  logic              mem_req,
  input  icache_pkg::addr_t mem_addr,
  output icache_pkg::word_t mem_rdata,
  output logic              mem_wait
);

  import icache_pkg::*;

  // Stretch sequence comes from its own copy of the seed
  integer seed = SEED;

  // One request in flight
  logic       busy;
  logic [1:0] stretch_cnt;
  word_t      rdata_q;

  // ==============================
  // Request and wait stretch
  // ==============================

  // Each word is held back by 0 to 3 cycles
  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy        <= 1'b0;
      stretch_cnt <= '0;
      rdata_q     <= '0;
    end
    else if (mem_req)
    begin
      busy        <= 1'b1;
      stretch_cnt <= 2'($random(seed));
      // Word content is a fixed function of its address
      rdata_q     <= mem_addr ^ PATTERN;
    end
    else if (busy)
    begin
      if (stretch_cnt == 2'd0)
      begin
        busy <= 1'b0;
      end
      else
      begin
        stretch_cnt <= stretch_cnt - 2'd1;
      end
    end
  end

  // Data valid in the first cycle with wait low
  assign mem_wait  = busy && (stretch_cnt != 2'd0);
  assign mem_rdata = rdata_q;

endmodule

`default_nettype wire

/* tb_icache.sv */
// Instruction cache testbench

`timescale 1ns/1ps
`default_nettype none

`include "icache_defines.svh"

module tb_icache;

  import icache_pkg::*;

  // Memory word at address A is A xor this pattern
  localparam word_t       MEM_PATTERN      = 32'h5a3c_96e1;
  localparam logic [31:0] SEED_INIT        = 32'hd79e36f1;
  localparam int          HIT_WAIT         = 2;
  localparam int          MISS_REQS        = `ICACHE_LINE_WORDS;
  localparam int          RANDOM_FETCHES   = 200;
  // About 220 fetches, 30 cycles at most each, plus reset margin
  localparam int          MAX_FETCH_CYCLES = 30;
  localparam int          TIMEOUT_CYCLES   = (RANDOM_FETCHES + 20) * MAX_FETCH_CYCLES + 400;

  logic  clk;
  logic  rst;
  logic  core_req;
  addr_t core_addr;
  word_t core_out;
  logic  core_wait;
  logic  mem_req;
  addr_t mem_addr;
  word_t mem_rdata;
  logic  mem_wait;

  integer seed;
  int     err_count   = 0;
  int     check_count = 0;
  int     tests_run   = 0;
  int     tests_fail  = 0;
  int     test_errs   = 0;
  int     cycle_count = 0;
  string  cur_test    = "init";

  // Memory request log and outstanding flag
  addr_t  req_log[$];
  int     req_start;
  logic   outstanding;

  // Results of the last fetch
  word_t  got_word;
  int     got_wait;
  int     got_reqs;

  // Shadow of the direct-mapped tag array
  tag_t                   shadow_tag [`ICACHE_LINES];
  logic [`ICACHE_LINES-1:0] shadow_valid;

  // ==============================
  // DUT and memory
  // ==============================

  icache_top u_icache_top (
    .clk       (clk),
    .rst       (rst),
    .core_req  (core_req),
    .core_addr (core_addr),
    .core_out  (core_out),
    .core_wait (core_wait),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_wait  (mem_wait)
  );

  tb_mem_model #(
    .PATTERN (MEM_PATTERN),
    .SEED    (SEED_INIT)
  ) u_mem (
    .clk       (clk),
    .rst       (rst),
    .mem_req   (mem_req),
    .mem_addr  (mem_addr),
    .mem_rdata (mem_rdata),
    .mem_wait  (mem_wait)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // Run limit
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation failed");
      $finish;
    end
  end

  // ==============================
  // Memory bus monitor
  // ==============================

  always @(posedge clk)
  begin
    if (rst)
    begin
      outstanding = 1'b0;
    end
    else
    begin
      // Word completes in the first later cycle with wait low
      if (outstanding && !mem_wait)
      begin
        outstanding = 1'b0;
      end
      if (mem_req)
      begin
        check_count++;
        assert (!outstanding)
        else
        begin
          err_count++;
          $display("Error in %s: new memory request while one was outstanding", cur_test);
        end
        outstanding = 1'b1;
        req_log.push_back(mem_addr);
      end
    end
  end

  // Refill traffic only while the core is stalled
  req_during_stall: assert property (@(posedge clk) disable iff (rst) mem_req |-> core_wait)
  else
  begin
    err_count++;
    $display("Error in %s: memory request while core_wait was low", cur_test);
  end

  // Request is a single-cycle pulse
  req_is_pulse: assert property (@(posedge clk) disable iff (rst) mem_req |-> !$past(mem_req))
  else
  begin
    err_count++;
    $display("Error in %s: mem_req held high for two cycles", cur_test);
  end

  // ==============================
  // Helpers
  // ==============================

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    check_count++;
    assert (act === exp)
    else
    begin
      err_count++;
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
    end
  endtask

  function automatic logic shadow_hit(input addr_t addr);
    index_t idx;
    idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    return shadow_valid[idx]
      && (shadow_tag[idx] == addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS]);
  endfunction

  task automatic shadow_fill(input addr_t addr);
    index_t idx;
    idx = addr[`ICACHE_OFFSET_BITS +: `ICACHE_INDEX_BITS];
    shadow_valid[idx] = 1'b1;
    shadow_tag[idx]   = addr[`ICACHE_ADDR_BITS-1 -: `ICACHE_TAG_BITS];
  endtask

  // One fetch, counting stall cycles and memory requests
  task automatic fetch(input addr_t addr);
    int waits;
    req_start = req_log.size();
    core_req  <= 1'b1;
    core_addr <= addr;
    @(posedge clk);
    core_req  <= 1'b0;
    check_value("wait in accepting cycle", 32'd1, {31'd0, core_wait});
    waits = 1;
    @(posedge clk);
    while (core_wait !== 1'b0)
    begin
      waits++;
      @(posedge clk);
    end
    got_word = core_out;
    got_wait = waits;
    got_reqs = req_log.size() - req_start;
  endtask

  // Fetch and compare against the memory pattern and the shadow
  task automatic fetch_and_check(input addr_t addr);
    logic  hit_pred;
    word_t exp_word;
    hit_pred = shadow_hit(addr);
    exp_word = {addr[`ICACHE_ADDR_BITS-1:2], 2'b00} ^ MEM_PATTERN;
    fetch(addr);
    check_value("word", exp_word, got_word);
    if (hit_pred)
    begin
      check_value("requests on hit", 32'd0, got_reqs);
      check_value("hit wait cycles", HIT_WAIT, got_wait);
    end
    else
    begin
      check_value("requests on miss", MISS_REQS, got_reqs);
      shadow_fill(addr);
    end
  endtask

  // Refill words go out as base plus 0, 4, 8, 12
  task automatic check_refill_order(input addr_t addr);
    addr_t base;
    base = {addr[`ICACHE_ADDR_BITS-1:`ICACHE_OFFSET_BITS], 4'b0000};
    if (got_reqs == MISS_REQS)
    begin
      for (int k = 0; k < MISS_REQS; k++)
      begin
        check_value("refill address", base + addr_t'(4 * k), req_log[req_start + k]);
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = err_count;
  endtask

  task automatic end_test();
    tests_run++;
    if (err_count == test_errs)
    begin
      $display("Test %s: ok", cur_test);
    end
    else
    begin
      tests_fail++;
      $display("Test %s: %0d errors", cur_test, err_count - test_errs);
    end
  endtask

  // ==============================
  // Stimulus
  // ==============================

  initial
  begin
    addr_t addr;
    seed         = SEED_INIT;
    rst          = 1'b1;
    core_req     = 1'b0;
    core_addr    = '0;
    shadow_valid = '0;
    repeat (2) @(posedge clk);
    rst <= 1'b0;

    // Idle outputs, then a first fetch must miss
    begin_test("reset");
    repeat (3)
    begin
      @(posedge clk);
      check_value("idle core_wait and mem_req", 32'd0, {30'd0, core_wait, mem_req});
    end
    fetch_and_check(32'h0000_2a40);
    check_value("first fetch requests", MISS_REQS, got_reqs);
    end_test();

    begin_test("cold_miss");
    fetch_and_check(32'h0000_1238);
    check_value("cold miss requests", MISS_REQS, got_reqs);
    check_refill_order(32'h0000_1238);
    end_test();

    // Same line again, every word
    begin_test("hit");
    fetch_and_check(32'h0000_1238);
    fetch_and_check(32'h0000_1230);
    fetch_and_check(32'h0000_1234);
    fetch_and_check(32'h0000_123c);
    check_value("hit requests", 32'd0, got_reqs);
    end_test();

    // 0x3450 and 0x3850 share index 5
    begin_test("conflict");
    fetch_and_check(32'h0000_3450);
    fetch_and_check(32'h0000_3850);
    check_value("conflict requests", MISS_REQS, got_reqs);
    fetch_and_check(32'h0000_3450);
    check_value("refetch requests", MISS_REQS, got_reqs);
    end_test();

    // 2 KiB window, two tags per index
    begin_test("random_stream");
    for (int i = 0; i < RANDOM_FETCHES; i++)
    begin
      addr = 32'h0001_0000 | (addr_t'($random(seed)) & 32'h0000_07fc);
      fetch_and_check(addr);
    end
    end_test();

    $display("Tests %0d, failed %0d, checks %0d, errors %0d",
      tests_run, tests_fail, check_count, err_count);
    if (err_count == 0)
    begin
      $display("Simulation passed");
    end
    else
    begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* compile.f */
+incdir+.
icache_pkg.sv
icache_tag_store.sv
icache_data_store.sv
icache_refill.sv
icache_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the instruction cache testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert --top-module tb_icache -Mdir obj_dir -f compile.f \
  && ./obj_dir/Vtb_icache > sim.log 2>&1 \
  || echo "Build or simulation run returned an error"

[ -f sim.log ] && cat sim.log

# A failure report anywhere in the log fails the script
grep -q "Simulation failed" sim.log && exit 1
grep -q "Simulation passed" sim.log || exit 1
exit 0
